// ==== common/scope_pkg.sv ====
package scope_pkg;

    localparam int ADC_WIDTH    = 14;   // ADC word and converted sample width
    localparam int BUFFER_DEPTH = 64;   // Samples per capture block
    localparam int ADDR_WIDTH   = 6;    // Buffer address width
    localparam int CLKS_PER_BIT = 16;   // Baud prescale in sys_clock cycles
    localparam int LED_STRETCH  = 256;  // Blue LED hold time after a command

    // Command bytes are plain ASCII so a terminal can drive the scope
    typedef enum logic [7:0] {
        CMD_SAMPLE = 8'h53,             // 'S' starts a capture
        CMD_DECIM  = 8'h44,             // 'D' takes one parameter byte
        CMD_ABORT  = 8'h52              // 'R' soft resets the sampler
    } cmd_opcode_t;

    typedef enum logic [1:0] {
        SMP_IDLE,
        SMP_FILL,
        SMP_SEND_LO,
        SMP_SEND_HI
    } sampler_state_t;

    typedef enum logic {
        CMD_WAIT_OP,
        CMD_WAIT_PARAM
    } cmd_state_t;

endpackage

// ==== hdl/adc_capture.sv ====
`timescale 1ns/1ps

module adc_capture (
    input  logic                            sys_clock,
    input  logic                            i_reset,
    input  logic [scope_pkg::ADC_WIDTH-1:0] i_adc_data,
    input  logic                            i_adc_valid,
    output logic [scope_pkg::ADC_WIDTH-1:0] o_sample,
    output logic                            o_sample_valid
);
    import scope_pkg::*;

    always_ff @(posedge sys_clock) begin
        if (i_reset) begin
            o_sample_valid <= 1'b0;
        end else begin
            o_sample_valid <= i_adc_valid;          // Valid follows the strobe by one cycle
        end
    end

    // Offset binary to two's complement is a flip of the MSB
    always_ff @(posedge sys_clock) begin
        if (i_adc_valid) begin
            o_sample <= {~i_adc_data[ADC_WIDTH-1], i_adc_data[ADC_WIDTH-2:0]};
        end
    end

endmodule

// ==== sampler/sampler.sv ====
`timescale 1ns/1ps

module sampler (
    input  logic                            sys_clock,
    input  logic                            i_reset,
    input  logic                            i_start,
    input  logic                            i_abort,
    input  logic [7:0]                      i_decim,
    input  logic [scope_pkg::ADC_WIDTH-1:0] i_sample,
    input  logic                            i_sample_valid,
    input  logic                            i_tx_ready,
    output logic [7:0]                      o_tx_byte,
    output logic                            o_tx_send,
    output logic                            o_busy
);
    import scope_pkg::*;

    localparam int HI_BITS = ADC_WIDTH - 8;

    sampler_state_t        state;
    logic [ADC_WIDTH-1:0]  buffer [BUFFER_DEPTH];
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH:0]   rd_ptr;                  // Extra bit marks the end of readout
    logic [7:0]            decim_count;
    logic [ADC_WIDTH-1:0]  rd_sample;
    logic [7:0]            lo_byte;
    logic [7:0]            hi_byte;
    logic                  store;
    logic                  tx_go;

    assign store     = (state == SMP_FILL) && i_sample_valid && (decim_count == 8'd0);
    assign rd_sample = buffer[rd_ptr[ADDR_WIDTH-1:0]];
    assign lo_byte   = rd_sample[7:0];
    assign hi_byte   = {{(8 - HI_BITS){rd_sample[ADC_WIDTH-1]}}, rd_sample[ADC_WIDTH-1:8]};
    assign tx_go     = i_tx_ready && !o_tx_send;    // Ready still reads high the cycle after a send
    assign o_busy    = (state != SMP_IDLE);

    always_ff @(posedge sys_clock) begin
        if (store) begin
            buffer[wr_ptr] <= i_sample;
        end
    end

    always_ff @(posedge sys_clock) begin
        if (o_busy && tx_go) begin
            o_tx_byte <= (state == SMP_SEND_HI) ? hi_byte : lo_byte;
        end
    end

    always_ff @(posedge sys_clock) begin
        if (i_reset) begin
            state       <= SMP_IDLE;
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            decim_count <= '0;
            o_tx_send   <= 1'b0;
        end else begin
            o_tx_send <= 1'b0;
            if (i_abort) begin
                state       <= SMP_IDLE;            // Decimation setting itself is kept
                decim_count <= '0;
            end else begin
                case (state)
                    SMP_IDLE: begin
                        if (i_start) begin
                            state       <= SMP_FILL;
                            wr_ptr      <= '0;
                            decim_count <= '0;
                        end
                    end
                    SMP_FILL: begin
                        if (i_sample_valid) begin
                            // Keep one sample out of every decim+1
                            if (decim_count >= i_decim) begin
                                decim_count <= '0;
                            end else begin
                                decim_count <= decim_count + 8'd1;
                            end
                        end
                        if (store) begin
                            wr_ptr <= wr_ptr + 1'b1;
                            if (wr_ptr == ADDR_WIDTH'(BUFFER_DEPTH - 1)) begin
                                state  <= SMP_SEND_LO;
                                rd_ptr <= '0;
                            end
                        end
                    end
                    SMP_SEND_LO: begin
                        if (tx_go) begin
                            if (rd_ptr == (ADDR_WIDTH + 1)'(BUFFER_DEPTH)) begin
                                state <= SMP_IDLE;  // Last stop bit is out
                            end else begin
                                o_tx_send <= 1'b1;
                                state     <= SMP_SEND_HI;
                            end
                        end
                    end
                    SMP_SEND_HI: begin
                        if (tx_go) begin
                            o_tx_send <= 1'b1;
                            rd_ptr    <= rd_ptr + 1'b1;
                            state     <= SMP_SEND_LO;
                        end
                    end
                    default: state <= SMP_IDLE;
                endcase
            end
        end
    end

endmodule

// ==== uart/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic       sys_clock,
    input  logic       i_reset,
    input  logic [7:0] i_byte,
    input  logic       i_send,
    output logic       o_tx,
    output logic       o_ready
);
    import scope_pkg::*;

    localparam int BAUD_WIDTH = $clog2(CLKS_PER_BIT);

    logic [BAUD_WIDTH-1:0] baud_count;
    logic [3:0]            bit_count;
    logic [8:0]            shift;                   // Data bits with the stop bit on top

    always_ff @(posedge sys_clock) begin
        if (i_reset) begin
            o_tx       <= 1'b1;
            o_ready    <= 1'b1;
            baud_count <= '0;
            bit_count  <= '0;
        end else if (o_ready) begin
            if (i_send) begin
                o_ready    <= 1'b0;
                o_tx       <= 1'b0;                 // Start bit
                baud_count <= '0;
                bit_count  <= '0;
            end
        end else if (baud_count == BAUD_WIDTH'(CLKS_PER_BIT - 1)) begin
            baud_count <= '0;
            if (bit_count == 4'd9) begin
                o_ready <= 1'b1;                    // Stop bit has run its full length
            end else begin
                o_tx      <= shift[0];
                bit_count <= bit_count + 4'd1;
            end
        end else begin
            baud_count <= baud_count + 1'b1;
        end
    end

    always_ff @(posedge sys_clock) begin
        if (o_ready && i_send) begin
            shift <= {1'b1, i_byte};
        end else if (!o_ready && baud_count == BAUD_WIDTH'(CLKS_PER_BIT - 1)) begin
            shift <= {1'b1, shift[8:1]};            // LSB first, ones fill in behind
        end
    end

endmodule

// ==== uart/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic       sys_clock,
    input  logic       i_reset,
    input  logic       i_rx,
    output logic [7:0] o_byte,
    output logic       o_valid
);
    import scope_pkg::*;

    localparam int BAUD_WIDTH = $clog2(CLKS_PER_BIT);

    logic                  rx_meta;
    logic                  rx_sync;
    logic                  rx_last;
    logic                  active;
    logic [BAUD_WIDTH-1:0] baud_count;              // Counts down to the next bit centre
    logic [3:0]            bit_count;
    logic [7:0]            shift;

    always_ff @(posedge sys_clock) begin
        if (i_reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    always_ff @(posedge sys_clock) begin
        if (i_reset) begin
            active     <= 1'b0;
            baud_count <= '0;
            bit_count  <= '0;
            o_valid    <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            if (!active) begin
                if (rx_last && !rx_sync) begin
                    active     <= 1'b1;         // Falling edge, wait half a bit
                    baud_count <= BAUD_WIDTH'(CLKS_PER_BIT / 2 - 1);
                    bit_count  <= '0;
                end
            end else if (baud_count != '0) begin
                baud_count <= baud_count - 1'b1;
            end else begin
                baud_count <= BAUD_WIDTH'(CLKS_PER_BIT - 1);
                if (bit_count == 4'd0 && rx_sync) begin
                    active <= 1'b0;             // Glitch, not a real start bit
                end else if (bit_count == 4'd9) begin
                    active  <= 1'b0;
                    o_valid <= rx_sync;         // Framing error drops the byte
                end else begin
                    bit_count <= bit_count + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge sys_clock) begin
        if (active && baud_count == '0 && bit_count != 4'd0 && bit_count != 4'd9) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

    always_ff @(posedge sys_clock) begin
        if (active && baud_count == '0 && bit_count == 4'd9) begin
            o_byte <= shift;
        end
    end

endmodule

// ==== hdl/command_unit.sv ====
`timescale 1ns/1ps

module command_unit (
    input  logic       sys_clock,
    input  logic       i_reset,
    input  logic [7:0] i_byte,
    input  logic       i_byte_valid,
    output logic       o_start,
    output logic       o_abort,
    output logic [7:0] o_decim,
    output logic       o_accepted
);
    import scope_pkg::*;

    cmd_state_t state;

    always_ff @(posedge sys_clock) begin
        if (i_reset) begin
            state      <= CMD_WAIT_OP;
            o_start    <= 1'b0;
            o_abort    <= 1'b0;
            o_decim    <= 8'd0;
            o_accepted <= 1'b0;
        end else begin
            o_start    <= 1'b0;
            o_abort    <= 1'b0;
            o_accepted <= 1'b0;
            if (i_byte_valid) begin
                case (state)
                    CMD_WAIT_OP: begin
                        case (i_byte)
                            CMD_SAMPLE: begin
                                o_start    <= 1'b1;
                                o_accepted <= 1'b1;
                            end
                            CMD_DECIM: begin
                                state      <= CMD_WAIT_PARAM;
                                o_accepted <= 1'b1;
                            end
                            CMD_ABORT: begin
                                o_abort    <= 1'b1;
                                o_accepted <= 1'b1;
                            end
                            default: ;                  // Unknown bytes are dropped
                        endcase
                    end
                    CMD_WAIT_PARAM: begin
                        o_decim    <= i_byte;           // Any value is a valid factor
                        o_accepted <= 1'b1;
                        state      <= CMD_WAIT_OP;
                    end
                    default: state <= CMD_WAIT_OP;
                endcase
            end
        end
    end

endmodule

// ==== hdl/status_unit.sv ====
`timescale 1ns/1ps

module status_unit (
    input  logic sys_clock,
    input  logic i_reset,
    input  logic i_busy,
    input  logic i_accepted,
    output logic o_led_r,
    output logic o_led_g,
    output logic o_led_b
);
    import scope_pkg::*;

    localparam int STRETCH_WIDTH = $clog2(LED_STRETCH + 1);

    logic [STRETCH_WIDTH-1:0] stretch_count;

    always_ff @(posedge sys_clock) begin
        if (i_reset) begin
            stretch_count <= '0;
        end else if (i_accepted) begin
            stretch_count <= STRETCH_WIDTH'(LED_STRETCH);   // Retrigger on every command
        end else if (stretch_count != '0) begin
            stretch_count <= stretch_count - 1'b1;
        end
    end

    assign o_led_r = i_busy;
    assign o_led_g = !i_busy;
    assign o_led_b = (stretch_count != '0);

endmodule

// ==== hdl/scope_top.sv ====
`timescale 1ns/1ps

module scope_top (
    input  logic                            sys_clock,
    input  logic                            i_reset,
    input  logic [scope_pkg::ADC_WIDTH-1:0] i_adc_data,
    input  logic                            i_adc_valid,
    input  logic                            i_sample,
    input  logic                            i_rx,
    output logic                            o_tx,
    output logic                            o_led_r,
    output logic                            o_led_g,
    output logic                            o_led_b
);
    import scope_pkg::*;

    logic [ADC_WIDTH-1:0] sample_data;
    logic                 sample_valid;
    logic                 start_request;
    logic [7:0]           tx_byte;
    logic                 tx_send;
    logic                 tx_ready;
    logic [7:0]           rx_byte;
    logic                 rx_valid;
    logic                 cmd_start;
    logic                 cmd_abort;
    logic [7:0]           decim_value;
    logic                 cmd_accepted;
    logic                 busy;

    assign start_request = i_sample || cmd_start;   // Sampler ignores it unless idle

    adc_capture u_adc_capture (
        .sys_clock      ( sys_clock     ),
        .i_reset        ( i_reset       ),
        .i_adc_data     ( i_adc_data    ),
        .i_adc_valid    ( i_adc_valid   ),
        .o_sample       ( sample_data   ),
        .o_sample_valid ( sample_valid  )
    );

    sampler u_sampler (
        .sys_clock      ( sys_clock     ),
        .i_reset        ( i_reset       ),
        .i_start        ( start_request ),
        .i_abort        ( cmd_abort     ),
        .i_decim        ( decim_value   ),
        .i_sample       ( sample_data   ),
        .i_sample_valid ( sample_valid  ),
        .i_tx_ready     ( tx_ready      ),
        .o_tx_byte      ( tx_byte       ),
        .o_tx_send      ( tx_send       ),
        .o_busy         ( busy          )
    );

    uart_tx u_uart_tx (
        .sys_clock      ( sys_clock     ),
        .i_reset        ( i_reset       ),
        .i_byte         ( tx_byte       ),
        .i_send         ( tx_send       ),
        .o_tx           ( o_tx          ),
        .o_ready        ( tx_ready      )
    );

    uart_rx u_uart_rx (
        .sys_clock      ( sys_clock     ),
        .i_reset        ( i_reset       ),
        .i_rx           ( i_rx          ),
        .o_byte         ( rx_byte       ),
        .o_valid        ( rx_valid      )
    );

    command_unit u_command_unit (
        .sys_clock      ( sys_clock     ),
        .i_reset        ( i_reset       ),
        .i_byte         ( rx_byte       ),
        .i_byte_valid   ( rx_valid      ),
        .o_start        ( cmd_start     ),
        .o_abort        ( cmd_abort     ),
        .o_decim        ( decim_value   ),
        .o_accepted     ( cmd_accepted  )
    );

    status_unit u_status_unit (
        .sys_clock      ( sys_clock     ),
        .i_reset        ( i_reset       ),
        .i_busy         ( busy          ),
        .i_accepted     ( cmd_accepted  ),
        .o_led_r        ( o_led_r       ),
        .o_led_g        ( o_led_g       ),
        .o_led_b        ( o_led_b       )
    );

endmodule

// ==== tb/scope_checker.sv ====
`timescale 1ns/1ps

module scope_checker (
    input  logic sys_clock,
    input  logic i_reset,
    input  logic i_tx
);
    import scope_pkg::*;

    logic [ADC_WIDTH-1:0] expected [$];
    logic [7:0]           lo_byte;
    logic                 have_lo;
    int                   error_count  = 0;
    int                   sample_count = 0;
    int                   byte_count   = 0;

    task automatic push_expected(input logic [ADC_WIDTH-1:0] value);
        expected.push_back(value);
    endtask

    task automatic flush_expected();
        expected.delete();
        have_lo = 1'b0;                             // A lone low byte is dropped too
    endtask

    task automatic note_failure(input string what);
        error_count++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    task automatic check_drained();
        if (expected.size() != 0) begin
            note_failure($sformatf("%0d expected samples never arrived", expected.size()));
        end
    endtask

    task automatic take_byte(input logic [7:0] value);
        logic [ADC_WIDTH-1:0] got;
        logic [ADC_WIDTH-1:0] want;
        byte_count++;
        if (!have_lo) begin
            lo_byte = value;
            have_lo = 1'b1;
        end else begin
            have_lo = 1'b0;
            sample_count++;
            got = {value[5:0], lo_byte};
            if (value[7:6] != {2{value[5]}}) begin
                error_count++;
                $display("[ERROR] %0t o_tx high byte not sign extended: expected %h got %h",
                         $time, {{2{value[5]}}, value[5:0]}, value);
            end
            if (expected.size() == 0) begin
                note_failure($sformatf("sample %h arrived with nothing expected", got));
            end else begin
                want = expected.pop_front();
                if (got !== want) begin
                    error_count++;
                    $display("[ERROR] %0t o_tx sample: expected %h got %h", $time, want, got);
                end
            end
        end
    endtask

    initial have_lo = 1'b0;

    // Frame decoder, sampling each bit near its centre
    always begin
        logic [7:0] frame;
        @(posedge sys_clock);
        if (!i_reset && i_tx === 1'b0) begin
            repeat (CLKS_PER_BIT / 2) @(posedge sys_clock);
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(posedge sys_clock);
                frame[i] = i_tx;
            end
            repeat (CLKS_PER_BIT) @(posedge sys_clock);
            if (i_tx !== 1'b1) begin
                note_failure("bad stop bit on o_tx");
            end
            take_byte(frame);
        end
    end

endmodule

// ==== tb/scope_props.sv ====
`timescale 1ns/1ps

module scope_props (
    input  logic                             sys_clock,
    input  logic                             i_reset,
    input  logic                             i_tx_send,
    input  logic                             i_tx_ready,
    input  logic                             i_tx,
    input  scope_pkg::sampler_state_t        i_state,
    input  logic [scope_pkg::ADDR_WIDTH-1:0] i_wr_ptr
);
    import scope_pkg::*;

    // The sampler hands over a byte only to an idle transmitter
    assert property (@(posedge sys_clock) disable iff (i_reset)
        i_tx_send |-> i_tx_ready)
        else $error("tx_send pulsed while the transmitter was busy");

    assert property (@(posedge sys_clock) disable iff (i_reset)
        i_tx_ready |-> i_tx)
        else $error("o_tx low while the transmitter reports ready");

    // Buffer writes belong to the fill phase only
    assert property (@(posedge sys_clock) disable iff (i_reset)
        (i_wr_ptr != '0 && i_wr_ptr == ADDR_WIDTH'($past(i_wr_ptr) + 1'b1))
        |-> ($past(i_state) == SMP_FILL))
        else $error("Write pointer advanced outside SMP_FILL");

endmodule

// ==== tb/tb_scope_top.sv ====
`timescale 1ns/1ps

module tb_scope_top;
    import scope_pkg::*;

    localparam int LED_R = 0;
    localparam int LED_G = 1;
    localparam int LED_B = 2;

    logic                 sys_clock = 1'b0;
    logic                 i_reset;
    logic [ADC_WIDTH-1:0] i_adc_data;
    logic                 i_adc_valid;
    logic                 i_sample;
    logic                 i_rx;
    logic                 o_tx;
    logic                 o_led_r;
    logic                 o_led_g;
    logic                 o_led_b;
    logic                 arm;
    int                   decim_model = 0;
    int                   timeout_count = 0;
    int                   pushed;
    int                   skip;
    int                   phase;

    always #10 sys_clock = ~sys_clock;              // 20 ns period

    scope_top i_scope_top (
        .sys_clock   ( sys_clock   ),
        .i_reset     ( i_reset     ),
        .i_adc_data  ( i_adc_data  ),
        .i_adc_valid ( i_adc_valid ),
        .i_sample    ( i_sample    ),
        .i_rx        ( i_rx        ),
        .o_tx        ( o_tx        ),
        .o_led_r     ( o_led_r     ),
        .o_led_g     ( o_led_g     ),
        .o_led_b     ( o_led_b     )
    );

    scope_checker u_scope_checker (
        .sys_clock ( sys_clock ),
        .i_reset   ( i_reset   ),
        .i_tx      ( o_tx      )
    );

    bind scope_top scope_props u_scope_props (
        .sys_clock  ( sys_clock        ),
        .i_reset    ( i_reset          ),
        .i_tx_send  ( tx_send          ),
        .i_tx_ready ( tx_ready         ),
        .i_tx       ( o_tx             ),
        .i_state    ( u_sampler.state  ),
        .i_wr_ptr   ( u_sampler.wr_ptr )
    );

    // ADC strobe every 4 cycles while armed, feeding the expected list
    always @(posedge sys_clock) begin
        logic [ADC_WIDTH-1:0] word;
        if (!arm) begin
            pushed = 0;
            skip = 0;
            phase = 0;
            i_adc_valid <= 1'b0;
        end else if (phase == 3 && pushed < BUFFER_DEPTH) begin
            phase = 0;
            word = ADC_WIDTH'($urandom);
            i_adc_data  <= word;
            i_adc_valid <= 1'b1;
            if (skip == 0) begin
                // Offset binary carries the signed value plus half of full scale
                u_scope_checker.push_expected(ADC_WIDTH'(int'(word) - (1 << (ADC_WIDTH - 1))));
                pushed++;
            end
            skip = (skip >= decim_model) ? 0 : skip + 1;
        end else begin
            phase = (phase == 3) ? 3 : phase + 1;
            i_adc_valid <= 1'b0;
        end
    end

    function automatic logic led_level(input int which);
        case (which)
            LED_R:   return o_led_r;
            LED_G:   return o_led_g;
            default: return o_led_b;
        endcase
    endfunction

    task automatic wait_level(input int which, input logic level, input int max_cycles,
                              input string what);
        int n;
        n = 0;
        while (led_level(which) !== level && n < max_cycles) begin
            @(posedge sys_clock);
            n++;
        end
        if (led_level(which) !== level) begin
            timeout_count++;
            $display("Timeout at %0t while waiting for %s", $time, what);
        end
    endtask

    task automatic wait_samples(input int target, input int max_cycles);
        int n;
        n = 0;
        while (u_scope_checker.sample_count < target && n < max_cycles) begin
            @(posedge sys_clock);
            n++;
        end
        if (u_scope_checker.sample_count < target) begin
            timeout_count++;
            $display("Timeout at %0t while waiting for readout samples", $time);
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge sys_clock);
            i_rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge sys_clock);
        end
        repeat (CLKS_PER_BIT) @(posedge sys_clock);
    endtask

    task automatic send_command(input logic [7:0] value);
        send_byte(value);
        wait_level(LED_B, 1'b1, 4 * CLKS_PER_BIT, "blue LED after a command");
        wait_level(LED_B, 1'b0, 2 * LED_STRETCH, "blue LED to clear");
    endtask

    task automatic pulse_sample();
        @(posedge sys_clock);
        i_sample <= 1'b1;
        @(posedge sys_clock);
        i_sample <= 1'b0;
    endtask

    task automatic run_capture();
        wait_level(LED_R, 1'b1, 200, "capture to start");
        arm <= 1'b1;
        wait_level(LED_R, 1'b0, 200000, "capture to finish");
        arm <= 1'b0;
        u_scope_checker.check_drained();
    endtask

    initial begin
        int base;
        logic [7:0] junk;
        i_reset     = 1'b1;
        i_adc_data  = '0;
        i_adc_valid = 1'b0;
        i_sample    = 1'b0;
        i_rx        = 1'b1;
        arm         = 1'b0;
        void'($urandom(1));
        repeat (16) @(posedge sys_clock);
        i_reset <= 1'b0;
        repeat (4) @(posedge sys_clock);

        // Pin start at decimation 0
        pulse_sample();
        run_capture();

        // Decimation and start over the serial command path
        decim_model = 1 + int'($urandom % 7);
        send_command(CMD_DECIM);
        send_command(8'(decim_model));
        send_byte(CMD_SAMPLE);
        wait_level(LED_B, 1'b1, 4 * CLKS_PER_BIT, "blue LED after a command");
        run_capture();
        wait_level(LED_B, 1'b0, 2 * LED_STRETCH, "blue LED to clear");

        // Start requests during readout are ignored
        base = u_scope_checker.sample_count;
        pulse_sample();
        wait_level(LED_R, 1'b1, 200, "capture to start");
        arm <= 1'b1;
        wait_samples(base + 4, 20000);
        pulse_sample();
        send_byte(CMD_SAMPLE);
        wait_level(LED_R, 1'b0, 200000, "capture to finish");
        arm <= 1'b0;
        u_scope_checker.check_drained();
        if (u_scope_checker.sample_count - base != BUFFER_DEPTH) begin
            u_scope_checker.note_failure("sample count differs from one buffer");
        end
        for (int i = 0; i < 2000; i++) begin
            @(posedge sys_clock);
            if (o_led_r) begin
                u_scope_checker.note_failure("capture restarted after readout");
                break;
            end
        end

        // Abort during readout, then a normal capture
        base = u_scope_checker.sample_count;
        pulse_sample();
        wait_level(LED_R, 1'b1, 200, "capture to start");
        arm <= 1'b1;
        wait_samples(base + 8, 20000);
        send_byte(CMD_ABORT);
        wait_level(LED_G, 1'b1, 4 * CLKS_PER_BIT, "abort to reach idle");
        base = u_scope_checker.byte_count;
        repeat (30 * CLKS_PER_BIT) @(posedge sys_clock);
        if (u_scope_checker.byte_count - base > 1) begin
            u_scope_checker.note_failure("more than one byte sent after abort");
        end
        arm <= 1'b0;
        u_scope_checker.flush_expected();
        wait_level(LED_B, 1'b0, 2 * LED_STRETCH, "blue LED to clear");
        pulse_sample();
        run_capture();

        // Unknown opcodes do nothing
        for (int i = 0; i < 4; i++) begin
            junk = 8'($urandom);
            while (junk == CMD_SAMPLE || junk == CMD_DECIM || junk == CMD_ABORT) begin
                junk = 8'($urandom);
            end
            send_byte(junk);
            if (o_led_b) begin
                u_scope_checker.note_failure("unknown opcode was accepted");
            end
        end
        for (int i = 0; i < 3000; i++) begin
            @(posedge sys_clock);
            if (o_tx !== 1'b1 || o_led_r || o_led_b) begin
                u_scope_checker.note_failure("activity after unknown opcodes");
                break;
            end
        end

        $display("Errors: %0d, timeouts: %0d", u_scope_checker.error_count, timeout_count);
        if (u_scope_checker.error_count == 0 && timeout_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== scope_top.f ====
common/scope_pkg.sv
hdl/adc_capture.sv
sampler/sampler.sv
uart/uart_tx.sv
uart/uart_rx.sv
hdl/command_unit.sv
hdl/status_unit.sv
hdl/scope_top.sv
tb/scope_checker.sv
tb/scope_props.sv
tb/tb_scope_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the scope testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f scope_top.f --top-module tb_scope_top -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
